// File: rtl/apb_host_port.sv
`timescale 1ns/10ps
`default_nettype none

module apb_host_port #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  logic                 clk,
   input  logic                 resetn,
   input  rv_sys_pkg::apb_req_t apb_req,
   output rv_sys_pkg::apb_rsp_t apb_rsp,
   input  rv_sys_pkg::status_t  status,
   output logic                 start,
   input  rv_sys_pkg::mem_req_t core_fetch_req,
   input  rv_sys_pkg::mem_req_t core_data_req,
   output rv_sys_pkg::mem_req_t imem_req,
   output rv_sys_pkg::mem_req_t dmem_req,
   input  rv_isa_pkg::word_t    imem_rdata,
   input  rv_isa_pkg::word_t    dmem_rdata
);
   import rv_sys_pkg::*;

   logic       setup;
   logic       access;
   logic       high_zero;
   logic       hit_imem;
   logic       hit_dmem;
   logic       hit_ctrl;
   logic       hit_mem;
   logic       start_wr;
   logic [1:0] region;
   logic [1:0] rd_region;
   mem_req_t   host_req;

   assign setup     = apb_req.psel && !apb_req.penable;
   assign access    = apb_req.psel && apb_req.penable;
   assign region    = apb_req.paddr[REGION_MSB:REGION_LSB];
   assign high_zero = apb_req.paddr[15:REGION_MSB+1] == '0;
   assign hit_imem  = high_zero && region == IMEM_BASE[REGION_MSB:REGION_LSB];
   assign hit_dmem  = high_zero && region == DMEM_BASE[REGION_MSB:REGION_LSB];
   assign hit_ctrl  = high_zero && region == CTRL_ADDR[REGION_MSB:REGION_LSB]
                      && apb_req.paddr[REGION_LSB-1:0] == CTRL_ADDR[REGION_LSB-1:0];
   assign hit_mem   = hit_imem || hit_dmem;
   assign start_wr  = access && apb_req.pwrite && hit_ctrl && apb_req.pwdata[0];
   assign start     = start_wr && !status.busy;

   // reads go out in setup, writes land in access
   always_comb begin
      host_req.addr  = 30'(apb_req.paddr[MEM_ADDR_WIDTH-1:2]);
      host_req.wdata = apb_req.pwdata;
      host_req.bwe   = {4{access && apb_req.pwrite}};
      host_req.ren   = setup && !apb_req.pwrite;
   end

   always_comb begin
      imem_req = core_fetch_req;
      dmem_req = core_data_req;
      if (!status.busy) begin
         imem_req     = host_req;
         imem_req.bwe = hit_imem ? host_req.bwe : 4'b0000;
         imem_req.ren = host_req.ren && hit_imem;
         dmem_req     = host_req;
         dmem_req.bwe = hit_dmem ? host_req.bwe : 4'b0000;
         dmem_req.ren = host_req.ren && hit_dmem;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_region <= '0;
      end else if (setup) begin
         rd_region <= region;
      end
   end

   always_comb begin
      case (rd_region)
         IMEM_BASE[REGION_MSB:REGION_LSB]: apb_rsp.prdata = imem_rdata;
         DMEM_BASE[REGION_MSB:REGION_LSB]: apb_rsp.prdata = dmem_rdata;
         CTRL_ADDR[REGION_MSB:REGION_LSB]: apb_rsp.prdata = {30'b0, status};
         default:                          apb_rsp.prdata = '0;
      endcase
      apb_rsp.pready  = access;
      apb_rsp.pslverr = access && (!(hit_mem || hit_ctrl)
                                   || (status.busy && hit_mem)
                                   || (status.busy && start_wr));
   end

   // access phase always follows a selected cycle
   assert property (@(posedge clk) disable iff (!resetn)
      apb_req.penable |-> $past(apb_req.psel));

endmodule

`default_nettype wire

// File: rtl/byte_ram.sv
`timescale 1ns/10ps
`default_nettype none

module byte_ram #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  logic                 clk,
   input  logic                 resetn,
   input  rv_sys_pkg::mem_req_t req,
   output rv_isa_pkg::word_t    rdata
);
   import rv_isa_pkg::*;

   localparam int DEPTH = 1 << (MEM_ADDR_WIDTH - 2);

   logic [MEM_ADDR_WIDTH-3:0] widx;
   word_t                     lane_rd;

   assign widx = req.addr[MEM_ADDR_WIDTH-3:0];

   for (genvar i = 0; i < 4; i++) begin : g_lane
      logic [7:0] mem [DEPTH];

      always_ff @(posedge clk) begin
         if (req.bwe[i]) begin
            mem[widx] <= req.wdata[8*i +: 8];
         end
      end

      assign lane_rd[8*i +: 8] = mem[widx];
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rdata <= '0;
      end else if (req.ren) begin
         rdata <= lane_rd;
      end
   end

   // requesters never mix a read and a write
   assert property (@(posedge clk) disable iff (!resetn) !(req.ren && (req.bwe != 4'b0000)));

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  logic                 clk,
   input  logic                 resetn,
   input  logic                 start,
   input  rv_isa_pkg::word_t    instr_word,
   output rv_sys_pkg::mem_req_t fetch_req,
   input  rv_isa_pkg::word_t    data_rdata,
   output rv_sys_pkg::mem_req_t data_req,
   output rv_sys_pkg::status_t  status
);
   import rv_isa_pkg::*;
   import rv_sys_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_DECODE,
      S_READ,
      S_EXECUTE,
      S_WRITEBACK
   } state_e;

   state_e    state;
   word_t     pc;
   word_t     regs [32];
   word_t     op1;
   word_t     op2;
   word_t     result;
   word_t     alu_out;
   word_t     eaddr;
   word_t     pc_plus4;
   word_t     load_value;
   rv_instr_t dec_now;
   rv_instr_t ir;
   mem_req_t  lsu_req;
   logic      is_halt;
   logic      store_en;
   logic      taken;

   rv_decode u_decode (
      .instr (instr_word),
      .dec   (dec_now)
   );

   assign is_halt  = dec_now.opcode == OPC_CUSTOM0 && dec_now.funct3 == F3_HALT;
   assign eaddr    = op1 + ir.imm;
   assign pc_plus4 = pc + 32'd4;
   assign store_en = state == S_EXECUTE && ir.opcode == OPC_STORE;
   // bne reuses eq, inverted here
   assign taken    = result[0] ^ (ir.funct3 == F3_BNE);

   rv_lsu u_lsu (
      .dec        (ir),
      .eaddr      (eaddr),
      .store_data (op2),
      .store_en   (store_en),
      .load_word  (data_rdata),
      .store_req  (lsu_req),
      .load_value (load_value)
   );

   always_comb begin
      case (ir.alu_op)
         ALU_SUB: alu_out = op1 - op2;
         ALU_EQ:  alu_out = {31'b0, op1 == op2};
         ALU_LT:  alu_out = {31'b0, $signed(op1) < $signed(op2)};
         ALU_LTU: alu_out = {31'b0, op1 < op2};
         ALU_GE:  alu_out = {31'b0, $signed(op1) >= $signed(op2)};
         ALU_GEU: alu_out = {31'b0, op1 >= op2};
         ALU_AND: alu_out = op1 & op2;
         ALU_OR:  alu_out = op1 | op2;
         ALU_XOR: alu_out = op1 ^ op2;
         default: alu_out = op1 + op2;
      endcase
   end

   always_comb begin
      fetch_req      = '0;
      fetch_req.addr = 30'(pc[MEM_ADDR_WIDTH-1:2]);
      fetch_req.ren  = state == S_FETCH;
      data_req       = lsu_req;
      data_req.ren   = state == S_EXECUTE && ir.opcode == OPC_LOAD;
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state  <= S_IDLE;
         pc     <= '0;
         status <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start) begin
                  state       <= S_FETCH;
                  pc          <= '0;
                  status.busy <= 1'b1;
                  status.done <= 1'b0;
               end
            end
            S_FETCH: state <= S_DECODE;
            S_DECODE: begin
               if (is_halt) begin
                  state       <= S_IDLE;
                  status.busy <= 1'b0;
                  status.done <= 1'b1;
               end else begin
                  state <= S_READ;
               end
            end
            S_READ: state <= S_EXECUTE;
            S_EXECUTE: state <= S_WRITEBACK;
            S_WRITEBACK: begin
               state <= S_FETCH;
               case (ir.opcode)
                  OPC_JAL:    pc <= pc + ir.imm;
                  OPC_JALR:   pc <= {eaddr[31:1], 1'b0};
                  OPC_BRANCH: pc <= taken ? pc + ir.imm : pc_plus4;
                  default:    pc <= pc_plus4;
               endcase
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_DECODE) begin
         ir <= dec_now;
      end
      if (state == S_READ) begin
         case (ir.opcode)
            OPC_AUIPC: op1 <= pc;
            OPC_LUI:   op1 <= '0;
            default:   op1 <= (ir.rs1 == 5'd0) ? '0 : regs[ir.rs1];
         endcase
         case (ir.opcode)
            OPC_OP, OPC_BRANCH, OPC_STORE: op2 <= (ir.rs2 == 5'd0) ? '0 : regs[ir.rs2];
            default:                       op2 <= ir.imm;
         endcase
      end
      if (state == S_EXECUTE) begin
         result <= alu_out;
      end
      if (state == S_WRITEBACK) begin
         case (ir.opcode)
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: regs[ir.rd] <= result;
            OPC_JAL, OPC_JALR:                      regs[ir.rd] <= pc_plus4;
            OPC_LOAD:                               regs[ir.rd] <= load_value;
            default: ;
         endcase
      end
   end

   // byte writes leave the core only in execute
   assert property (@(posedge clk) disable iff (!resetn)
      (data_req.bwe != 4'b0000) |-> (state == S_EXECUTE));

endmodule

`default_nettype wire

// File: rtl/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
   input  rv_isa_pkg::word_t     instr,
   output rv_isa_pkg::rv_instr_t dec
);
   import rv_isa_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   alu_op_e    arith_op;

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // only register form has sub
   always_comb begin
      case (funct3)
         F3_ADD:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
         F3_SLT:  arith_op = ALU_LT;
         F3_SLTU: arith_op = ALU_LTU;
         F3_XOR:  arith_op = ALU_XOR;
         F3_OR:   arith_op = ALU_OR;
         F3_AND:  arith_op = ALU_AND;
         default: arith_op = ALU_ADD;
      endcase
   end

   always_comb begin
      dec.opcode = opcode;
      dec.rd     = instr[11:7];
      dec.rs1    = instr[19:15];
      dec.rs2    = instr[24:20];
      dec.funct3 = funct3;

      case (opcode)
         OPC_LUI, OPC_AUIPC: dec.imm = imm_u;
         OPC_JAL:            dec.imm = imm_j;
         OPC_BRANCH:         dec.imm = imm_b;
         OPC_STORE:          dec.imm = imm_s;
         default:            dec.imm = imm_i;
      endcase

      case (opcode)
         OPC_OP, OPC_OP_IMM: dec.alu_op = arith_op;
         OPC_BRANCH: begin
            case (funct3)
               F3_BEQ, F3_BNE: dec.alu_op = ALU_EQ;
               F3_BLT:         dec.alu_op = ALU_LT;
               F3_BGE:         dec.alu_op = ALU_GE;
               F3_BLTU:        dec.alu_op = ALU_LTU;
               F3_BGEU:        dec.alu_op = ALU_GEU;
               default:        dec.alu_op = ALU_EQ;
            endcase
         end
         default: dec.alu_op = ALU_ADD;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   typedef logic [31:0] word_t;

   // major opcodes kept by the core
   typedef enum logic [6:0] {
      OPC_LUI     = 7'b0110111,
      OPC_AUIPC   = 7'b0010111,
      OPC_OP      = 7'b0110011,
      OPC_OP_IMM  = 7'b0010011,
      OPC_JAL     = 7'b1101111,
      OPC_JALR    = 7'b1100111,
      OPC_BRANCH  = 7'b1100011,
      OPC_LOAD    = 7'b0000011,
      OPC_STORE   = 7'b0100011,
      OPC_CUSTOM0 = 7'b0001011
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_EQ,
      ALU_LT,
      ALU_LTU,
      ALU_GE,
      ALU_GEU,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   // alu funct3, shared by OP and OP_IMM
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   localparam logic [2:0] F3_LB   = 3'b000;
   localparam logic [2:0] F3_LH   = 3'b001;
   localparam logic [2:0] F3_LW   = 3'b010;
   localparam logic [2:0] F3_LBU  = 3'b100;
   localparam logic [2:0] F3_LHU  = 3'b101;

   localparam logic [2:0] F3_SB   = 3'b000;
   localparam logic [2:0] F3_SH   = 3'b001;
   localparam logic [2:0] F3_SW   = 3'b010;

   // custom0
   localparam logic [2:0] F3_HALT = 3'b001;

   typedef struct packed {
      opcode_e    opcode;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [2:0] funct3;
      alu_op_e    alu_op;
      word_t      imm;
   } rv_instr_t;

endpackage

`default_nettype wire

// File: rtl/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
   input  rv_isa_pkg::rv_instr_t dec,
   input  rv_isa_pkg::word_t     eaddr,
   input  rv_isa_pkg::word_t     store_data,
   input  logic                  store_en,
   input  rv_isa_pkg::word_t     load_word,
   output rv_sys_pkg::mem_req_t  store_req,
   output rv_isa_pkg::word_t     load_value
);
   import rv_isa_pkg::*;

   logic [7:0]  load_byte;
   logic [15:0] load_half;

   assign load_byte = load_word[{eaddr[1:0], 3'b000} +: 8];
   assign load_half = eaddr[1] ? load_word[31:16] : load_word[15:0];

   // replicate into every lane, bwe picks the live ones
   always_comb begin
      store_req      = '0;
      store_req.addr = eaddr[31:2];
      case (dec.funct3)
         F3_SB: begin
            store_req.wdata = {4{store_data[7:0]}};
            store_req.bwe   = store_en ? (4'b0001 << eaddr[1:0]) : 4'b0000;
         end
         F3_SH: begin
            store_req.wdata = {2{store_data[15:0]}};
            store_req.bwe   = store_en ? (eaddr[1] ? 4'b1100 : 4'b0011) : 4'b0000;
         end
         F3_SW: begin
            store_req.wdata = store_data;
            store_req.bwe   = {4{store_en}};
         end
         default: store_req.wdata = store_data;
      endcase
   end

   always_comb begin
      case (dec.funct3)
         F3_LB:   load_value = {{24{load_byte[7]}}, load_byte};
         F3_LBU:  load_value = {24'b0, load_byte};
         F3_LH:   load_value = {{16{load_half[15]}}, load_half};
         F3_LHU:  load_value = {16'b0, load_half};
         F3_LW:   load_value = load_word;
         default: load_value = load_word;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/rv_sys_pkg.sv
`default_nettype none

package rv_sys_pkg;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [15:0] paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // word addressed, one bwe bit per byte lane
   typedef struct packed {
      logic [29:0] addr;
      logic [31:0] wdata;
      logic [3:0]  bwe;
      logic        ren;
   } mem_req_t;

   typedef struct packed {
      logic busy;
      logic done;
   } status_t;

   localparam logic [15:0] IMEM_BASE = 16'h0000;
   localparam logic [15:0] DMEM_BASE = 16'h1000;
   localparam logic [15:0] CTRL_ADDR = 16'h2000;

   // region select bits of paddr
   localparam int REGION_MSB = 13;
   localparam int REGION_LSB = 12;

endpackage

`default_nettype wire

// File: rtl/rv_system.sv
`timescale 1ns/10ps
`default_nettype none

module rv_system #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  logic                 clk,
   input  logic                 resetn,
   input  rv_sys_pkg::apb_req_t apb_req,
   output rv_sys_pkg::apb_rsp_t apb_rsp,
   output logic                 halt
);
   import rv_isa_pkg::*;
   import rv_sys_pkg::*;

   status_t  status;
   logic     start;
   mem_req_t core_fetch_req;
   mem_req_t core_data_req;
   mem_req_t imem_req;
   mem_req_t dmem_req;
   word_t    imem_rdata;
   word_t    dmem_rdata;

   assign halt = status.done;

   byte_ram #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_imem (
      .clk    (clk),
      .resetn (resetn),
      .req    (imem_req),
      .rdata  (imem_rdata)
   );

   byte_ram #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_dmem (
      .clk    (clk),
      .resetn (resetn),
      .req    (dmem_req),
      .rdata  (dmem_rdata)
   );

   rv_core #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_core (
      .clk        (clk),
      .resetn     (resetn),
      .start      (start),
      .instr_word (imem_rdata),
      .fetch_req  (core_fetch_req),
      .data_rdata (dmem_rdata),
      .data_req   (core_data_req),
      .status     (status)
   );

   apb_host_port #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_host (
      .clk            (clk),
      .resetn         (resetn),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .status         (status),
      .start          (start),
      .core_fetch_req (core_fetch_req),
      .core_data_req  (core_data_req),
      .imem_req       (imem_req),
      .dmem_req       (dmem_req),
      .imem_rdata     (imem_rdata),
      .dmem_rdata     (dmem_rdata)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_rv_system \
   -Mdir obj_dir -o tb_rv_system
./obj_dir/tb_rv_system > sim.log 2>&1
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0

// File: sim.f
rtl/rv_isa_pkg.sv
rtl/rv_sys_pkg.sv
rtl/byte_ram.sv
rtl/rv_decode.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
rtl/apb_host_port.sv
rtl/rv_system.sv
+incdir+tests
tests/tb_rv_system.sv

// File: tests/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [6:0] OPC_R   = 7'b0110011;
localparam logic [6:0] OPC_I   = 7'b0010011;
localparam logic [6:0] OPC_LD  = 7'b0000011;
localparam logic [6:0] OPC_JR  = 7'b1100111;
localparam logic [15:0] CTRL   = 16'h2000;

function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
   return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_R};
endfunction

function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
   return {12'(imm), 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic word_t enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
   logic [11:0] w;
   w = imm;
   return {w[11:5], 5'(rs2), 5'(rs1), f3, w[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(int imm, int rs1, int rs2, logic [2:0] f3);
   logic [12:0] b;
   b = 13'(imm);
   return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], 7'b1100011};
endfunction

function automatic word_t enc_u(logic [19:0] imm, int rd, logic [6:0] op);
   return {imm, 5'(rd), op};
endfunction

function automatic word_t enc_j(int imm, int rd);
   logic [20:0] j;
   j = 21'(imm);
   return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic add_row(string name, row_op_e op, logic [15:0] addr, word_t wdata,
                       word_t exp, logic err);
   row_t r;
   r.op    = op;
   r.addr  = addr;
   r.wdata = wdata;
   r.exp   = exp;
   r.err   = err;
   rows.push_back(r);
   names.push_back(name);
endtask

// branch over one addi that marks the not-taken path
task automatic add_branch(logic [2:0] f3, int rs1, int rs2, int acc, int mark);
   prog.push_back(enc_b(8, rs1, rs2, f3));
   prog.push_back(enc_i(mark, acc, 3'b000, acc, OPC_I));
endtask

task automatic build_program();
   prog.push_back(enc_u(20'h12345, 1, 7'b0110111));
   auipc_pc = 4 * prog.size();
   prog.push_back(enc_u(20'h00001, 2, 7'b0010111));
   prog.push_back(enc_i(-5, 0, 3'b000, 3, OPC_I));
   prog.push_back(enc_i(7, 0, 3'b000, 4, OPC_I));
   prog.push_back(enc_r(7'b0000000, 4, 3, 3'b000, 5));
   prog.push_back(enc_r(7'b0100000, 3, 4, 3'b000, 6));
   prog.push_back(enc_r(7'b0000000, 4, 3, 3'b010, 7));
   prog.push_back(enc_r(7'b0000000, 4, 3, 3'b011, 8));
   prog.push_back(enc_r(7'b0000000, 4, 1, 3'b100, 9));
   prog.push_back(enc_r(7'b0000000, 4, 3, 3'b110, 10));
   prog.push_back(enc_r(7'b0000000, 4, 3, 3'b111, 11));
   prog.push_back(enc_s(12'h100, 1, 0, 3'b010));
   prog.push_back(enc_s(12'h104, 2, 0, 3'b010));
   prog.push_back(enc_s(12'h108, 3, 0, 3'b010));
   prog.push_back(enc_s(12'h10C, 5, 0, 3'b010));
   prog.push_back(enc_s(12'h110, 6, 0, 3'b010));
   prog.push_back(enc_s(12'h114, 7, 0, 3'b010));
   prog.push_back(enc_s(12'h118, 8, 0, 3'b010));
   prog.push_back(enc_s(12'h11C, 9, 0, 3'b010));
   prog.push_back(enc_s(12'h120, 10, 0, 3'b010));
   prog.push_back(enc_s(12'h124, 11, 0, 3'b010));
   // loads of the known word at 0x200
   prog.push_back(enc_i('h201, 0, 3'b000, 12, OPC_LD));
   prog.push_back(enc_i('h201, 0, 3'b100, 13, OPC_LD));
   prog.push_back(enc_i('h200, 0, 3'b001, 14, OPC_LD));
   prog.push_back(enc_i('h202, 0, 3'b101, 15, OPC_LD));
   prog.push_back(enc_i('h200, 0, 3'b000, 16, OPC_LD));
   prog.push_back(enc_s(12'h128, 12, 0, 3'b010));
   prog.push_back(enc_s(12'h12C, 13, 0, 3'b010));
   prog.push_back(enc_s(12'h130, 14, 0, 3'b010));
   prog.push_back(enc_s(12'h134, 15, 0, 3'b010));
   prog.push_back(enc_s(12'h138, 16, 0, 3'b010));
   prog.push_back(enc_s(12'h210, 9, 0, 3'b000));
   prog.push_back(enc_s(12'h215, 9, 0, 3'b000));
   prog.push_back(enc_s(12'h21A, 9, 0, 3'b000));
   prog.push_back(enc_s(12'h21F, 9, 0, 3'b000));
   prog.push_back(enc_s(12'h220, 9, 0, 3'b001));
   prog.push_back(enc_s(12'h226, 9, 0, 3'b001));
   prog.push_back(enc_i(0, 0, 3'b000, 20, OPC_I));
   prog.push_back(enc_i(0, 0, 3'b000, 21, OPC_I));
   add_branch(3'b000, 3, 4, 20, 1);
   add_branch(3'b000, 4, 4, 20, 2);
   add_branch(3'b001, 3, 4, 20, 4);
   add_branch(3'b001, 4, 4, 20, 8);
   add_branch(3'b100, 3, 4, 20, 16);
   add_branch(3'b100, 4, 3, 20, 32);
   add_branch(3'b101, 4, 3, 21, 1);
   add_branch(3'b101, 3, 4, 21, 2);
   add_branch(3'b110, 4, 3, 21, 4);
   add_branch(3'b110, 3, 4, 21, 8);
   add_branch(3'b111, 3, 4, 21, 16);
   add_branch(3'b111, 4, 3, 21, 32);
   jal_pc = 4 * prog.size();
   prog.push_back(enc_j(8, 22));
   prog.push_back(enc_i(0, 0, 3'b000, 22, OPC_I));
   jalr_base = 4 * prog.size();
   prog.push_back(enc_u(20'h00000, 24, 7'b0010111));
   prog.push_back(enc_i(12, 24, 3'b000, 25, OPC_JR));
   prog.push_back(enc_i(0, 0, 3'b000, 25, OPC_I));
   prog.push_back(enc_s(12'h13C, 20, 0, 3'b010));
   prog.push_back(enc_s(12'h140, 21, 0, 3'b010));
   prog.push_back(enc_s(12'h144, 22, 0, 3'b010));
   prog.push_back(enc_s(12'h148, 25, 0, 3'b010));
   prog.push_back({17'b0, 3'b001, 5'b0, 7'b0001011});
   // must never execute
   prog.push_back(enc_s(12'h14C, 1, 0, 3'b010));
endtask

task automatic build_table();
   add_row("reset status", OP_RD, CTRL, '0, 32'h0, 1'b0);
   add_row("unmapped read", OP_RD, 16'h3000, '0, '0, 1'b1);
   add_row("unmapped ctrl word", OP_WR, 16'h2004, 32'h1, '0, 1'b1);
   for (int i = 0; i < 4; i++) begin
      add_row("random write", OP_WRAND, 16'(16'h1300 + 4 * i), '0, '0, 1'b0);
   end
   for (int i = 0; i < 4; i++) begin
      add_row("random readback", OP_RDRAND, 16'(16'h1300 + 4 * i), '0, '0, 1'b0);
   end
   add_row("load word", OP_WR, 16'h1200, 32'hA5C38E71, '0, 1'b0);
   for (int i = 0; i < 6; i++) begin
      add_row("store target", OP_WR, 16'(16'h1210 + 4 * i), 32'h11223344, '0, 1'b0);
   end
   add_row("after halt guard", OP_WR, 16'h114C, 32'h5A5A5A5A, '0, 1'b0);
   foreach (prog[i]) begin
      add_row("imem load", OP_WR, 16'(4 * i), prog[i], '0, 1'b0);
   end
   add_row("imem readback", OP_RD, 16'h0000, '0, prog[0], 1'b0);
   add_row("start", OP_WR, CTRL, 32'h1, '0, 1'b0);
   add_row("busy status", OP_RD, CTRL, '0, 32'h2, 1'b0);
   add_row("busy dmem read", OP_RD, 16'h1100, '0, '0, 1'b1);
   add_row("busy start", OP_WR, CTRL, 32'h1, '0, 1'b1);
   add_row("busy imem write", OP_WR, 16'h0000, 32'h0, '0, 1'b1);
   add_row("wait done", OP_POLL, CTRL, '0, 32'h1, 1'b0);
   add_row("halted status", OP_RD, CTRL, '0, 32'h1, 1'b0);
   add_row("lui", OP_RD, 16'h1100, '0, 32'h12345 << 12, 1'b0);
   add_row("auipc", OP_RD, 16'h1104, '0, 32'(auipc_pc) + 32'h1000, 1'b0);
   add_row("addi neg", OP_RD, 16'h1108, '0, -32'sd5, 1'b0);
   add_row("add", OP_RD, 16'h110C, '0, -32'sd5 + 32'sd7, 1'b0);
   add_row("sub", OP_RD, 16'h1110, '0, 32'sd7 - -32'sd5, 1'b0);
   add_row("slt", OP_RD, 16'h1114, '0, 32'd1, 1'b0);
   add_row("sltu", OP_RD, 16'h1118, '0, 32'd0, 1'b0);
   add_row("xor", OP_RD, 16'h111C, '0, 32'h12345000 ^ 32'd7, 1'b0);
   add_row("or", OP_RD, 16'h1120, '0, 32'hFFFFFFFB | 32'd7, 1'b0);
   add_row("and", OP_RD, 16'h1124, '0, 32'hFFFFFFFB & 32'd7, 1'b0);
   add_row("lb neg", OP_RD, 16'h1128, '0, 32'hFFFFFF8E, 1'b0);
   add_row("lbu", OP_RD, 16'h112C, '0, 32'h0000008E, 1'b0);
   add_row("lh neg", OP_RD, 16'h1130, '0, 32'hFFFF8E71, 1'b0);
   add_row("lhu", OP_RD, 16'h1134, '0, 32'h0000A5C3, 1'b0);
   add_row("lb pos", OP_RD, 16'h1138, '0, 32'h00000071, 1'b0);
   add_row("sb off0", OP_RD, 16'h1210, '0, 32'h11223307, 1'b0);
   add_row("sb off1", OP_RD, 16'h1214, '0, 32'h11220744, 1'b0);
   add_row("sb off2", OP_RD, 16'h1218, '0, 32'h11073344, 1'b0);
   add_row("sb off3", OP_RD, 16'h121C, '0, 32'h07223344, 1'b0);
   add_row("sh off0", OP_RD, 16'h1220, '0, 32'h11225007, 1'b0);
   add_row("sh off2", OP_RD, 16'h1224, '0, 32'h50073344, 1'b0);
   // not-taken marks 1, 8, 32 in group a and 2, 8, 32 in group b
   add_row("branch group a", OP_RD, 16'h113C, '0, 32'd41, 1'b0);
   add_row("branch group b", OP_RD, 16'h1140, '0, 32'd42, 1'b0);
   add_row("jal link", OP_RD, 16'h1144, '0, 32'(jal_pc + 4), 1'b0);
   add_row("jalr link", OP_RD, 16'h1148, '0, 32'(jalr_base + 8), 1'b0);
   add_row("no store after halt", OP_RD, 16'h114C, '0, 32'h5A5A5A5A, 1'b0);
endtask

`endif

// File: tests/tb_rv_system.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_system;
   import rv_isa_pkg::*;
   import rv_sys_pkg::*;

   typedef enum logic [2:0] {
      OP_WR,
      OP_RD,
      OP_POLL,
      OP_WRAND,
      OP_RDRAND
   } row_op_e;

   typedef struct packed {
      row_op_e     op;
      logic [15:0] addr;
      word_t       wdata;
      word_t       exp;
      logic        err;
   } row_t;

   logic     clk;
   logic     resetn;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;
   logic     halt;

   row_t  rows[$];
   string names[$];
   word_t prog[$];
   word_t rand_words[$];
   int    auipc_pc;
   int    jal_pc;
   int    jalr_base;
   int    errors = 0;
   int    checks = 0;
   int    cycles = 0;
   int    cycle_limit = 0;

   `include "tb_program.svh"

   rv_system #(.MEM_ADDR_WIDTH(12)) u_dut (
      .clk     (clk),
      .resetn  (resetn),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .halt    (halt)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic check_word(string name, word_t exp, word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_status(string name, status_t exp, status_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s expected busy %b done %b actual busy %b done %b",
                  name, exp.busy, exp.done, act.busy, act.done);
      end
   endtask

   task automatic check_err(string name, logic exp, logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s expected pslverr %b actual %b", name, exp, act);
      end
   endtask

   // back to back transfers, setup then access, sampled mid access cycle
   task automatic apb_xfer(logic write, logic [15:0] addr, word_t wdata,
                           output word_t rdata, output logic err);
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= write;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      if (apb_rsp.pready !== 1'b1) begin
         errors++;
         $display("pready was low in an access cycle at address %h", addr);
      end
   endtask

   task automatic run_row(int idx);
      row_t    r;
      word_t   rdata;
      word_t   wval;
      logic    err;
      status_t st;
      r = rows[idx];
      case (r.op)
         OP_WR: apb_xfer(1'b1, r.addr, r.wdata, rdata, err);
         OP_WRAND: begin
            wval = $urandom;
            rand_words.push_back(wval);
            apb_xfer(1'b1, r.addr, wval, rdata, err);
         end
         OP_POLL: begin
            do begin
               apb_xfer(1'b0, r.addr, '0, rdata, err);
            end while (rdata[0] !== 1'b1);
         end
         default: apb_xfer(1'b0, r.addr, '0, rdata, err);
      endcase
      check_err(names[idx], r.err, err);
      if (!r.err) begin
         if (r.op == OP_RDRAND) begin
            check_word(names[idx], rand_words.pop_front(), rdata);
         end else if (r.op == OP_POLL || (r.op == OP_RD && r.addr == CTRL)) begin
            st = rdata[1:0];
            check_status(names[idx], status_t'(r.exp[1:0]), st);
            if (halt !== r.exp[0]) begin
               errors++;
               $display("halt output does not follow done in %s", names[idx]);
            end
         end else if (r.op == OP_RD) begin
            check_word(names[idx], r.exp, rdata);
         end
      end
   endtask

   initial begin
      resetn  = 1'b0;
      apb_req = '0;
      void'($urandom(32'h0b45f517));
      build_program();
      build_table();
      cycle_limit = 3 * rows.size() + 5 * prog.size() + 50;
      repeat (3) @(posedge clk);
      resetn <= 1'b1;
      foreach (rows[i]) begin
         run_row(i);
      end
      @(posedge clk);
      apb_req <= '0;
      @(posedge clk);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
